/* Bender.yml */
package:
  name: rv_ctrl_unit

sources:
  - files:
      - source/rv_ctrl_pkg.sv
      - source/inst_capture.sv
      - source/ctrl_decode.sv
      - source/ctrl_issue.sv
      - source/rv_ctrl_unit.sv
  - target: test
    files:
      - test/rv_ctrl_unit_assert.sv
      - test/rv_ctrl_unit_tb.sv

/* rv_ctrl_unit.f */
source/rv_ctrl_pkg.sv
source/inst_capture.sv
source/ctrl_decode.sv
source/ctrl_issue.sv
source/rv_ctrl_unit.sv
test/rv_ctrl_unit_assert.sv
test/rv_ctrl_unit_tb.sv

/* source/ctrl_decode.sv */
// RV32 control word decoder
`timescale 1ns/100ps
`default_nettype none

module ctrl_decode (
    input  logic [rv_ctrl_pkg::INST_W-1:0] held_inst,
    input  logic                           held_eq,
    input  logic                           held_lt,
    input  logic                           held_ltu,
    output rv_ctrl_pkg::alu_op_e           alu_op,
    output rv_ctrl_pkg::op1_sel_e          op1_sel,
    output rv_ctrl_pkg::op2_sel_e          op2_sel,
    output rv_ctrl_pkg::pc_sel_e           pc_sel,
    output logic                           rf_we,
    output logic                           mem_en,
    output logic                           mem_wen,
    output rv_ctrl_pkg::wb_sel_e           wb_sel,
    output rv_ctrl_pkg::mem_access_e       mem_access,
    output logic                           is_ebreak
);

    rv_ctrl_pkg::opcode_e                opcode;
    rv_ctrl_pkg::branch_f3_e             br_f3;
    logic [rv_ctrl_pkg::FUNCT3_W-1:0]    funct3;
    logic [rv_ctrl_pkg::FUNCT7_W-1:0]    funct7;
    logic                                r_legal;    // funct7 allowed for R-type
    logic                                i_legal;    // funct7 allowed for shift-imm
    logic                                i_alt;      // SRAI
    logic                                br_legal;
    logic                                br_taken;

    // Base op from funct3, alt picks SUB / SRA
    function automatic rv_ctrl_pkg::alu_op_e alu_from_f3(
        input logic [rv_ctrl_pkg::FUNCT3_W-1:0] f3,
        input logic                             alt
    );
        rv_ctrl_pkg::alu_op_e op;
        op = rv_ctrl_pkg::ALU_ADD;
        case (f3)
            3'b000: op = alt ? rv_ctrl_pkg::ALU_SUB : rv_ctrl_pkg::ALU_ADD;
            3'b001: op = rv_ctrl_pkg::ALU_SLL;
            3'b010: op = rv_ctrl_pkg::ALU_SLT;
            3'b011: op = rv_ctrl_pkg::ALU_SLTU;
            3'b100: op = rv_ctrl_pkg::ALU_XOR;
            3'b101: op = alt ? rv_ctrl_pkg::ALU_SRA : rv_ctrl_pkg::ALU_SRL;
            3'b110: op = rv_ctrl_pkg::ALU_OR;
            3'b111: op = rv_ctrl_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode = rv_ctrl_pkg::opcode_e'(held_inst[rv_ctrl_pkg::OPC_MSB:0]);
    assign funct3 = held_inst[rv_ctrl_pkg::F3_MSB:rv_ctrl_pkg::F3_LSB];
    assign funct7 = held_inst[rv_ctrl_pkg::F7_MSB:rv_ctrl_pkg::F7_LSB];
    assign br_f3  = rv_ctrl_pkg::branch_f3_e'(funct3);

    // Alt funct7 only on ADD/SUB and shift-right slots
    assign r_legal = (funct7 == rv_ctrl_pkg::FUNCT7_BASE) ||
                     ((funct7 == rv_ctrl_pkg::FUNCT7_ALT) &&
                      (funct3 == rv_ctrl_pkg::F3_ADDSUB || funct3 == rv_ctrl_pkg::F3_SR));
    // Upper imm bits are don't-care except on SRLI/SRAI
    assign i_legal = (funct3 != rv_ctrl_pkg::F3_SR) ||
                     (funct7 == rv_ctrl_pkg::FUNCT7_BASE) ||
                     (funct7 == rv_ctrl_pkg::FUNCT7_ALT);
    assign i_alt   = (funct3 == rv_ctrl_pkg::F3_SR) && (funct7 == rv_ctrl_pkg::FUNCT7_ALT);

    assign is_ebreak = (held_inst == rv_ctrl_pkg::EBREAK_INST);  // Whole word match

    // Branch condition against the captured flags
    always_comb begin
        br_legal = 1'b1;
        br_taken = 1'b0;
        case (br_f3)
            rv_ctrl_pkg::BEQ:  br_taken = held_eq;
            rv_ctrl_pkg::BNE:  br_taken = ~held_eq;
            rv_ctrl_pkg::BLT:  br_taken = held_lt;
            rv_ctrl_pkg::BGE:  br_taken = ~held_lt;
            rv_ctrl_pkg::BLTU: br_taken = held_ltu;
            rv_ctrl_pkg::BGEU: br_taken = ~held_ltu;
            default:           br_legal = 1'b0;    // funct3 010 / 011
        endcase
    end

    always_comb begin
        // Zero word unless a row matches
        alu_op     = rv_ctrl_pkg::ALU_ADD;
        op1_sel    = rv_ctrl_pkg::OP1_RS1;
        op2_sel    = rv_ctrl_pkg::OP2_NONE;
        pc_sel     = rv_ctrl_pkg::PC_PLUS4;
        rf_we      = 1'b0;
        mem_en     = 1'b0;
        mem_wen    = 1'b0;
        wb_sel     = rv_ctrl_pkg::WB_NONE;
        mem_access = rv_ctrl_pkg::MEM_B;

        case (opcode)
            rv_ctrl_pkg::OP_REG: if (r_legal) begin
                alu_op  = alu_from_f3(funct3, funct7 == rv_ctrl_pkg::FUNCT7_ALT);
                op2_sel = rv_ctrl_pkg::OP2_RS2;
                rf_we   = 1'b1;
                wb_sel  = rv_ctrl_pkg::WB_ALU;
            end
            rv_ctrl_pkg::OP_IMM: if (i_legal) begin
                alu_op  = alu_from_f3(funct3, i_alt);    // SRLI maps to SRL
                op2_sel = rv_ctrl_pkg::OP2_IMM_I;
                rf_we   = 1'b1;
                wb_sel  = rv_ctrl_pkg::WB_ALU;
            end
            rv_ctrl_pkg::OP_LOAD: case (funct3)
                3'b000, 3'b001, 3'b010, 3'b100, 3'b101: begin  // LB LH LW LBU LHU
                    op2_sel    = rv_ctrl_pkg::OP2_IMM_I;
                    rf_we      = 1'b1;
                    mem_en     = 1'b1;
                    wb_sel     = rv_ctrl_pkg::WB_MEM;
                    mem_access = rv_ctrl_pkg::mem_access_e'(funct3);
                end
                default: ;
            endcase
            rv_ctrl_pkg::OP_STORE: case (funct3)
                3'b000, 3'b001, 3'b010: begin                  // SB SH SW
                    op2_sel    = rv_ctrl_pkg::OP2_IMM_S;
                    mem_en     = 1'b1;
                    mem_wen    = 1'b1;
                    mem_access = rv_ctrl_pkg::mem_access_e'(funct3);
                end
                default: ;
            endcase
            rv_ctrl_pkg::OP_BRANCH: if (br_legal) begin
                wb_sel = rv_ctrl_pkg::WB_ALU;
                pc_sel = br_taken ? rv_ctrl_pkg::PC_BRANCH : rv_ctrl_pkg::PC_PLUS4;
            end
            rv_ctrl_pkg::OP_JAL: begin
                pc_sel = rv_ctrl_pkg::PC_JAL;
                rf_we  = 1'b1;
                wb_sel = rv_ctrl_pkg::WB_PC4;                  // Link address
            end
            rv_ctrl_pkg::OP_JALR: if (funct3 == rv_ctrl_pkg::F3_JALR) begin
                op2_sel = rv_ctrl_pkg::OP2_IMM_I;
                pc_sel  = rv_ctrl_pkg::PC_JALR;
                rf_we   = 1'b1;
                wb_sel  = rv_ctrl_pkg::WB_PC4;
            end
            rv_ctrl_pkg::OP_AUIPC: begin
                op1_sel = rv_ctrl_pkg::OP1_PC;
                rf_we   = 1'b1;
                wb_sel  = rv_ctrl_pkg::WB_ALU;
            end
            // EBREAK only raises is_ebreak, rest of the word stays zero
            rv_ctrl_pkg::OP_SYSTEM: ;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* source/ctrl_issue.sv */
// Control word issue register
`timescale 1ns/100ps
`default_nettype none

module ctrl_issue (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     held_valid,     // Capture slot full
    input  rv_ctrl_pkg::alu_op_e     dec_alu_op,
    input  rv_ctrl_pkg::op1_sel_e    dec_op1_sel,
    input  rv_ctrl_pkg::op2_sel_e    dec_op2_sel,
    input  rv_ctrl_pkg::pc_sel_e     dec_pc_sel,
    input  logic                     dec_rf_we,
    input  logic                     dec_mem_en,
    input  logic                     dec_mem_wen,
    input  rv_ctrl_pkg::wb_sel_e     dec_wb_sel,
    input  rv_ctrl_pkg::mem_access_e dec_mem_access,
    input  logic                     dec_is_ebreak,
    input  logic                     out_ack,        // Four-phase ack from sink
    output logic                     take,           // Frees the capture slot
    output logic                     out_req,        // Four-phase request to sink
    output rv_ctrl_pkg::alu_op_e     alu_op,
    output rv_ctrl_pkg::op1_sel_e    op1_sel,
    output rv_ctrl_pkg::op2_sel_e    op2_sel,
    output rv_ctrl_pkg::pc_sel_e     pc_sel,
    output logic                     rf_we,
    output logic                     mem_en,
    output logic                     mem_wen,
    output rv_ctrl_pkg::wb_sel_e     wb_sel,
    output rv_ctrl_pkg::mem_access_e mem_access,
    output logic                     is_ebreak
);

    // Load only when the previous handshake has fully returned to zero
    assign take = held_valid & ~out_req & ~out_ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_req <= 1'b0;
        end else if (take) begin
            out_req <= 1'b1;               // New word on the bus
        end else if (out_ack) begin
            out_req <= 1'b0;               // Sink has it
        end
    end

    // Word held steady for the whole request phase
    always_ff @(posedge clk) begin
        if (take) begin
            alu_op     <= dec_alu_op;
            op1_sel    <= dec_op1_sel;
            op2_sel    <= dec_op2_sel;
            pc_sel     <= dec_pc_sel;
            rf_we      <= dec_rf_we;
            mem_en     <= dec_mem_en;
            mem_wen    <= dec_mem_wen;
            wb_sel     <= dec_wb_sel;
            mem_access <= dec_mem_access;
            is_ebreak  <= dec_is_ebreak;
        end
    end

endmodule

`default_nettype wire

/* source/inst_capture.sv */
// Instruction capture slot
`timescale 1ns/100ps
`default_nettype none

module inst_capture (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           in_req,     // Four-phase request from source
    input  logic [rv_ctrl_pkg::INST_W-1:0] inst,       // Stable while in_req high
    input  logic                           br_eq,      // rs1 == rs2
    input  logic                           br_lt,      // rs1 < rs2 signed
    input  logic                           br_ltu,     // rs1 < rs2 unsigned
    input  logic                           take,       // Issue side consumed the slot
    output logic                           in_ack,     // Four-phase acknowledge
    output logic                           held_valid, // Slot full
    output logic [rv_ctrl_pkg::INST_W-1:0] held_inst,
    output logic                           held_eq,
    output logic                           held_lt,
    output logic                           held_ltu
);

    logic fill;  // Accept this request

    // New request, not yet acked, room in the slot
    assign fill = in_req & ~in_ack & ~held_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_ack     <= 1'b0;
            held_valid <= 1'b0;
        end else begin
            if (fill) begin
                in_ack <= 1'b1;            // Ack one edge after req seen
            end else if (!in_req) begin
                in_ack <= 1'b0;            // Return to zero after req drops
            end

            if (take) begin
                held_valid <= 1'b0;        // Take wins over a fill
            end else if (fill) begin
                held_valid <= 1'b1;
            end
        end
    end

    // Payload, only written on accept
    always_ff @(posedge clk) begin
        if (fill) begin
            held_inst <= inst;
            held_eq   <= br_eq;
            held_lt   <= br_lt;
            held_ltu  <= br_ltu;
        end
    end

endmodule

`default_nettype wire

/* source/rv_ctrl_pkg.sv */
// RV32 control decode definitions
`default_nettype none

package rv_ctrl_pkg;

    // Instruction field geometry
    localparam int INST_W   = 32;       // Instruction word width
    localparam int OPCODE_W = 7;        // Major opcode width
    localparam int FUNCT3_W = 3;        // funct3 width
    localparam int FUNCT7_W = 7;        // funct7 width
    localparam int OPC_MSB  = 6;        // Opcode sits in [6:0]
    localparam int F3_LSB   = 12;       // funct3 sits in [14:12]
    localparam int F3_MSB   = 14;
    localparam int F7_LSB   = 25;       // funct7 sits in [31:25]
    localparam int F7_MSB   = 31;

    // Exact word, opcode alone is not enough
    localparam logic [INST_W-1:0] EBREAK_INST = 32'h0010_0073;

    localparam logic [FUNCT7_W-1:0] FUNCT7_BASE = 7'h00;  // Normal R-type / shift
    localparam logic [FUNCT7_W-1:0] FUNCT7_ALT  = 7'h20;  // SUB, SRA, SRAI

    localparam logic [FUNCT3_W-1:0] F3_ADDSUB = 3'b000;   // ADD/SUB slot
    localparam logic [FUNCT3_W-1:0] F3_SR     = 3'b101;   // Shift right slot
    localparam logic [FUNCT3_W-1:0] F3_JALR   = 3'b000;   // Only legal JALR funct3

    // Major opcodes, standard RV32 encodings
    typedef enum logic [OPCODE_W-1:0] {
        OP_LOAD   = 7'b0000011,
        OP_IMM    = 7'b0010011,
        OP_AUIPC  = 7'b0010111,
        OP_STORE  = 7'b0100011,
        OP_REG    = 7'b0110011,
        OP_BRANCH = 7'b1100011,
        OP_JALR   = 7'b1100111,
        OP_JAL    = 7'b1101111,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // Branch conditions by funct3
    typedef enum logic [FUNCT3_W-1:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_f3_e;

    typedef enum logic [4:0] {
        ALU_ADD  = 5'd0,
        ALU_SUB  = 5'd1,
        ALU_SLT  = 5'd2,
        ALU_SLTU = 5'd3,
        ALU_XOR  = 5'd4,
        ALU_OR   = 5'd5,
        ALU_AND  = 5'd6,
        ALU_SLL  = 5'd7,
        ALU_SRL  = 5'd8,
        ALU_SRA  = 5'd9
    } alu_op_e;

    typedef enum logic [1:0] {OP1_RS1 = 2'd0, OP1_PC = 2'd1} op1_sel_e;

    typedef enum logic [1:0] {
        OP2_NONE = 2'd0, OP2_IMM_I = 2'd1, OP2_IMM_S = 2'd2, OP2_RS2 = 2'd3
    } op2_sel_e;

    typedef enum logic [2:0] {
        PC_PLUS4 = 3'd0, PC_JALR = 3'd1, PC_BRANCH = 3'd2, PC_JAL = 3'd3
    } pc_sel_e;

    typedef enum logic [1:0] {
        WB_NONE = 2'd0, WB_PC4 = 2'd1, WB_ALU = 2'd2, WB_MEM = 2'd3
    } wb_sel_e;

    // Same code as the load/store funct3
    typedef enum logic [2:0] {
        MEM_B = 3'd0, MEM_H = 3'd1, MEM_W = 3'd2, MEM_BU = 3'd4, MEM_HU = 3'd5
    } mem_access_e;

endpackage

`default_nettype wire

/* source/rv_ctrl_unit.sv */
// RV32 control unit with handshake ports
`timescale 1ns/100ps
`default_nettype none

module rv_ctrl_unit (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           in_req,
    input  logic [rv_ctrl_pkg::INST_W-1:0] inst,
    input  logic                           br_eq,
    input  logic                           br_lt,
    input  logic                           br_ltu,
    input  logic                           out_ack,
    output logic                           in_ack,
    output logic                           out_req,
    output rv_ctrl_pkg::alu_op_e           alu_op,
    output rv_ctrl_pkg::op1_sel_e          op1_sel,
    output rv_ctrl_pkg::op2_sel_e          op2_sel,
    output rv_ctrl_pkg::pc_sel_e           pc_sel,
    output logic                           rf_we,
    output logic                           mem_en,
    output logic                           mem_wen,
    output rv_ctrl_pkg::wb_sel_e           wb_sel,
    output rv_ctrl_pkg::mem_access_e       mem_access,
    output logic                           is_ebreak
);

    // Capture slot to decoder
    logic                           held_valid;
    logic [rv_ctrl_pkg::INST_W-1:0] held_inst;
    logic                           held_eq;
    logic                           held_lt;
    logic                           held_ltu;
    logic                           take;        // Issue side pops the slot

    // Decoder to issue register
    rv_ctrl_pkg::alu_op_e     dec_alu_op;
    rv_ctrl_pkg::op1_sel_e    dec_op1_sel;
    rv_ctrl_pkg::op2_sel_e    dec_op2_sel;
    rv_ctrl_pkg::pc_sel_e     dec_pc_sel;
    logic                     dec_rf_we;
    logic                     dec_mem_en;
    logic                     dec_mem_wen;
    rv_ctrl_pkg::wb_sel_e     dec_wb_sel;
    rv_ctrl_pkg::mem_access_e dec_mem_access;
    logic                     dec_is_ebreak;

    inst_capture u_capture (
        .clk, .reset, .in_req, .inst, .br_eq, .br_lt, .br_ltu, .take,
        .in_ack, .held_valid, .held_inst, .held_eq, .held_lt, .held_ltu
    );

    ctrl_decode u_decode (
        .held_inst, .held_eq, .held_lt, .held_ltu,
        .alu_op     (dec_alu_op),
        .op1_sel    (dec_op1_sel),
        .op2_sel    (dec_op2_sel),
        .pc_sel     (dec_pc_sel),
        .rf_we      (dec_rf_we),
        .mem_en     (dec_mem_en),
        .mem_wen    (dec_mem_wen),
        .wb_sel     (dec_wb_sel),
        .mem_access (dec_mem_access),
        .is_ebreak  (dec_is_ebreak)
    );

    ctrl_issue u_issue (
        .clk, .reset, .held_valid,
        .dec_alu_op, .dec_op1_sel, .dec_op2_sel, .dec_pc_sel, .dec_rf_we,
        .dec_mem_en, .dec_mem_wen, .dec_wb_sel, .dec_mem_access, .dec_is_ebreak,
        .out_ack, .take, .out_req,
        .alu_op, .op1_sel, .op2_sel, .pc_sel, .rf_we,
        .mem_en, .mem_wen, .wb_sel, .mem_access, .is_ebreak
    );

endmodule

`default_nettype wire

/* test/rv_ctrl_tests.txt */
# name inst(hex) eq lt ltu ack_delay(-1 random) | expected:
# alu op1 op2 pc rf_we mem_en mem_wen wb mem_access is_ebreak
add_r    003100b3 0 0 0  0  0 0 3 0 1 0 0 2 0 0
sub_r    403100b3 0 0 0 -1  1 0 3 0 1 0 0 2 0 0
sra_r    403150b3 0 0 0 -1  9 0 3 0 1 0 0 2 0 0
sltu_r   003130b3 0 0 0  2  3 0 3 0 1 0 0 2 0 0
addi     00510093 0 0 0 -1  0 0 1 0 1 0 0 2 0 0
srli     00315093 0 0 0 -1  8 0 1 0 1 0 0 2 0 0
srai     40315093 0 0 0  0  9 0 1 0 1 0 0 2 0 0
lb       00010083 0 0 0 -1  0 0 1 0 1 1 0 3 0 0
lh       00011083 0 0 0  1  0 0 1 0 1 1 0 3 1 0
lw       00012083 0 0 0 -1  0 0 1 0 1 1 0 3 2 0
lbu      00014083 0 0 0 -1  0 0 1 0 1 1 0 3 4 0
lhu      00015083 0 0 0  3  0 0 1 0 1 1 0 3 5 0
sb       00310023 0 0 0 -1  0 0 2 0 0 1 1 0 0 0
sh       00311023 0 0 0 -1  0 0 2 0 0 1 1 0 1 0
sw       00312023 0 0 0  0  0 0 2 0 0 1 1 0 2 0
beq_t    00310063 1 0 0 -1  0 0 0 2 0 0 0 2 0 0
beq_n    00310063 0 1 1 -1  0 0 0 0 0 0 0 2 0 0
bne_t    00311063 0 1 1  0  0 0 0 2 0 0 0 2 0 0
bne_n    00311063 1 0 0 -1  0 0 0 0 0 0 0 2 0 0
blt_t    00314063 0 1 0 -1  0 0 0 2 0 0 0 2 0 0
blt_n    00314063 1 0 1  2  0 0 0 0 0 0 0 2 0 0
bge_t    00315063 1 0 1 -1  0 0 0 2 0 0 0 2 0 0
bge_n    00315063 0 1 0 -1  0 0 0 0 0 0 0 2 0 0
bltu_t   00316063 0 0 1  1  0 0 0 2 0 0 0 2 0 0
bltu_n   00316063 1 1 0 -1  0 0 0 0 0 0 0 2 0 0
bgeu_t   00317063 1 1 0 -1  0 0 0 2 0 0 0 2 0 0
bgeu_n   00317063 0 0 1  0  0 0 0 0 0 0 0 2 0 0
jal      000000ef 0 0 0 -1  0 0 0 3 1 0 0 1 0 0
jalr     000100e7 0 0 0 -1  0 0 1 1 1 0 0 1 0 0
auipc    00001097 0 0 0  3  0 1 0 0 1 0 0 2 0 0
ebreak   00100073 0 0 0 -1  0 0 0 0 0 0 0 0 0 1
ecall    00000073 0 0 0 -1  0 0 0 0 0 0 0 0 0 0
r_mul    023100b3 0 0 0  0  0 0 0 0 0 0 0 0 0 0
jalr_f3  000110e7 0 0 0 -1  0 0 0 0 0 0 0 0 0 0

/* test/rv_ctrl_unit_assert.sv */
// Handshake protocol assertions
`timescale 1ns/100ps
`default_nettype none

module rv_ctrl_unit_assert (
    input logic                     clk,
    input logic                     reset,
    input logic                     in_req,
    input logic                     in_ack,
    input logic                     out_req,
    input logic                     out_ack,
    input rv_ctrl_pkg::alu_op_e     alu_op,
    input rv_ctrl_pkg::op1_sel_e    op1_sel,
    input rv_ctrl_pkg::op2_sel_e    op2_sel,
    input rv_ctrl_pkg::pc_sel_e     pc_sel,
    input logic                     rf_we,
    input logic                     mem_en,
    input logic                     mem_wen,
    input rv_ctrl_pkg::wb_sel_e     wb_sel,
    input rv_ctrl_pkg::mem_access_e mem_access,
    input logic                     is_ebreak
);

    int violations = 0;    // Failed assertions so far

    // Ack only answers a request seen on the edge before
    ack_needs_req: assert property (@(posedge clk) disable iff (reset)
        $rose(in_ack) |-> $past(in_req))
        else begin
            $error("in_ack rose without in_req");
            violations++;
        end

    req_held: assert property (@(posedge clk) disable iff (reset)
        out_req && !out_ack |=> out_req)
        else begin
            $error("out_req dropped before out_ack");
            violations++;
        end

    // Word frozen while offered and on the edge that sees the ack
    word_stable: assert property (@(posedge clk) disable iff (reset)
        out_req |=> $stable({alu_op, op1_sel, op2_sel, pc_sel, rf_we, mem_en, mem_wen,
                             wb_sel, mem_access, is_ebreak}))
        else begin
            $error("Control word changed while out_req was high");
            violations++;
        end

    req_falls_after_ack: assert property (@(posedge clk) disable iff (reset)
        $fell(out_req) |-> $past(out_ack))
        else begin
            $error("out_req fell without out_ack");
            violations++;
        end

    reset_idle: assert property (@(posedge clk)
        reset |=> !in_ack && !out_req)
        else begin
            $error("Handshake outputs not idle after reset");
            violations++;
        end

endmodule

bind rv_ctrl_unit rv_ctrl_unit_assert u_assert (.*);

`default_nettype wire

/* test/rv_ctrl_unit_tb.sv */
// Control unit testbench
`timescale 1ns/100ps
`default_nettype none

module rv_ctrl_unit_tb;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 8;
    localparam int CYCLES_PER_TEST = 14;   // Output round trip plus slow ack
    localparam int MAX_TESTS       = 64;

    logic                           clk;
    logic                           reset;
    logic                           in_req;
    logic [rv_ctrl_pkg::INST_W-1:0] inst;
    logic                           br_eq;
    logic                           br_lt;
    logic                           br_ltu;
    logic                           out_ack;
    logic                           in_ack;
    logic                           out_req;
    rv_ctrl_pkg::alu_op_e           alu_op;
    rv_ctrl_pkg::op1_sel_e          op1_sel;
    rv_ctrl_pkg::op2_sel_e          op2_sel;
    rv_ctrl_pkg::pc_sel_e           pc_sel;
    logic                           rf_we;
    logic                           mem_en;
    logic                           mem_wen;
    rv_ctrl_pkg::wb_sel_e           wb_sel;
    rv_ctrl_pkg::mem_access_e       mem_access;
    logic                           is_ebreak;

    // Test table from the data file
    string       t_name  [MAX_TESTS];
    logic [31:0] t_inst  [MAX_TESTS];
    logic [2:0]  t_flags [MAX_TESTS];      // eq, lt, ltu
    int          t_delay [MAX_TESTS];      // -1 draws a random delay
    int          t_exp   [MAX_TESTS][10];  // Expected fields in file order

    int     n_tests;
    int     pass_count;
    int     fail_count;
    int     test_errors;                   // Mismatches in the current test
    integer seed;
    logic   tests_loaded;

    rv_ctrl_unit u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_alu_op(input string tname, input rv_ctrl_pkg::alu_op_e exp, act);
        if (act !== exp) begin
            $display("[ERROR] %s alu_op expected %0d actual %0d", tname, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_op1_sel(input string tname, input rv_ctrl_pkg::op1_sel_e exp, act);
        if (act !== exp) begin
            $display("[ERROR] %s op1_sel expected %0d actual %0d", tname, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_op2_sel(input string tname, input rv_ctrl_pkg::op2_sel_e exp, act);
        if (act !== exp) begin
            $display("[ERROR] %s op2_sel expected %0d actual %0d", tname, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_pc_sel(input string tname, input rv_ctrl_pkg::pc_sel_e exp, act);
        if (act !== exp) begin
            $display("[ERROR] %s pc_sel expected %0d actual %0d", tname, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_wb_sel(input string tname, input rv_ctrl_pkg::wb_sel_e exp, act);
        if (act !== exp) begin
            $display("[ERROR] %s wb_sel expected %0d actual %0d", tname, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_mem_access(input string tname,
                                    input rv_ctrl_pkg::mem_access_e exp, act);
        if (act !== exp) begin
            $display("[ERROR] %s mem_access expected %0d actual %0d", tname, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string tname, input string field, input logic exp, act);
        if (act !== exp) begin
            $display("[ERROR] %s %s expected %0b actual %0b", tname, field, exp, act);
            test_errors++;
        end
    endtask

    // Four-phase source with one instruction per round trip
    task automatic drive_all();
        for (int i = 0; i < n_tests; i++) begin
            @(posedge clk);
            inst   <= t_inst[i];
            br_eq  <= t_flags[i][2];
            br_lt  <= t_flags[i][1];
            br_ltu <= t_flags[i][0];
            in_req <= 1'b1;
            do @(posedge clk); while (!in_ack);
            in_req <= 1'b0;                    // Data held until here
            do @(posedge clk); while (in_ack);
        end
    endtask

    // Four-phase sink that expects results in send order
    task automatic respond_all();
        int dly;
        for (int i = 0; i < n_tests; i++) begin
            @(posedge clk);
            while (!out_req) @(posedge clk);
            test_errors = 0;
            check_alu_op(t_name[i], rv_ctrl_pkg::alu_op_e'(t_exp[i][0]), alu_op);
            check_op1_sel(t_name[i], rv_ctrl_pkg::op1_sel_e'(t_exp[i][1]), op1_sel);
            check_op2_sel(t_name[i], rv_ctrl_pkg::op2_sel_e'(t_exp[i][2]), op2_sel);
            check_pc_sel(t_name[i], rv_ctrl_pkg::pc_sel_e'(t_exp[i][3]), pc_sel);
            check_bit(t_name[i], "rf_we", t_exp[i][4][0], rf_we);
            check_bit(t_name[i], "mem_en", t_exp[i][5][0], mem_en);
            check_bit(t_name[i], "mem_wen", t_exp[i][6][0], mem_wen);
            check_wb_sel(t_name[i], rv_ctrl_pkg::wb_sel_e'(t_exp[i][7]), wb_sel);
            check_mem_access(t_name[i], rv_ctrl_pkg::mem_access_e'(t_exp[i][8]), mem_access);
            check_bit(t_name[i], "is_ebreak", t_exp[i][9][0], is_ebreak);
            dly = t_delay[i];
            if (dly < 0) begin
                dly = $unsigned($random(seed)) % 8;   // Back-pressure 0 to 7 cycles
            end
            repeat (dly) @(posedge clk);
            out_ack <= 1'b1;
            @(posedge clk);
            while (out_req) @(posedge clk);
            out_ack <= 1'b0;
            if (test_errors == 0) begin
                pass_count++;
                $display("PASS %s", t_name[i]);
            end else begin
                fail_count++;
                $display("FAIL %s with %0d mismatches", t_name[i], test_errors);
            end
        end
    endtask

    initial begin
        int          fd;
        int          items;
        string       line;
        string       name;
        logic [31:0] word;
        int          eq;
        int          lt;
        int          ltu;
        int          dly;
        int          f [10];
        reset        = 1'b1;
        in_req       = 1'b0;
        inst         = '0;
        br_eq        = 1'b0;
        br_lt        = 1'b0;
        br_ltu       = 1'b0;
        out_ack      = 1'b0;
        seed         = 32'hc8ae74d5;
        n_tests      = 0;
        pass_count   = 0;
        fail_count   = 0;
        tests_loaded = 1'b0;
        fd = $fopen("test/rv_ctrl_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/rv_ctrl_tests.txt");
            fail_count++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;                      // Blank or column header
                end
                items = $sscanf(line, "%s %h %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                                name, word, eq, lt, ltu, dly, f[0], f[1], f[2], f[3],
                                f[4], f[5], f[6], f[7], f[8], f[9]);
                if (items != 16) begin
                    $display("Malformed line in the test data file: %s", line);
                    fail_count++;
                end else if (n_tests < MAX_TESTS) begin
                    t_name[n_tests]  = name;
                    t_inst[n_tests]  = word;
                    t_flags[n_tests] = {eq[0], lt[0], ltu[0]};
                    t_delay[n_tests] = dly;
                    for (int k = 0; k < 10; k++) begin
                        t_exp[n_tests][k] = f[k];
                    end
                    n_tests++;
                end
            end
            $fclose(fd);
        end
        tests_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        if (n_tests == 0) begin
            $display("No tests were read, nothing was run");
            fail_count++;
        end else begin
            fork
                drive_all();
                respond_all();
            join
        end
        if (u_dut.u_assert.violations != 0) begin
            $display("Handshake protocol assertions failed %0d times",
                     u_dut.u_assert.violations);
            fail_count++;
        end
        $display("Summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Budget scales with the number of tests
    initial begin
        wait (tests_loaded === 1'b1);
        #((n_tests * CYCLES_PER_TEST + RESET_CYCLES) * CLK_PERIOD);
        $display("Timeout, the handshakes did not finish in the allowed time");
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire
